// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_tb
RTL_TOP   ?= lsu_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Simulation passed

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
source/lsu_pkg.sv
source/wait_timer.sv
source/store_align.sv
source/load_extract.sv
source/word_ram.sv
source/lsu_fsm.sv
source/lsu_top.sv
tests/tb_clock_gen.sv
tests/lsu_properties.sv
tests/lsu_tb.sv

// ==== source/load_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_extract (
  input  lsu_pkg::lsu_req_t        req_i,
  input  logic [lsu_pkg::XLEN-1:0] rdata_i,
  output logic [lsu_pkg::XLEN-1:0] data_o
);
  import lsu_pkg::*;

  logic [2:0]      off;
  logic [XLEN-1:0] sh;

  assign off = req_i.addr[2:0];

  // addressed byte down to lane 0
  assign sh = rdata_i >> {off, 3'b000};

  always_comb begin
    case (req_i.op)
      // signed loads replicate the top loaded bit
      OP_LB: begin
        data_o = {{(XLEN-8){sh[7]}}, sh[7:0]};
      end
      OP_LH: begin
        data_o = {{(XLEN-16){sh[15]}}, sh[15:0]};
      end
      OP_LW: begin
        data_o = {{(XLEN-32){sh[31]}}, sh[31:0]};
      end
      // unsigned loads
      OP_LBU: begin
        data_o = {{(XLEN-8){1'b0}}, sh[7:0]};
      end
      OP_LHU: begin
        data_o = {{(XLEN-16){1'b0}}, sh[15:0]};
      end
      OP_LWU: begin
        data_o = {{(XLEN-32){1'b0}}, sh[31:0]};
      end
      // LD keeps the whole word and stores never use the result
      default: begin
        data_o = sh;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/lsu_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_fsm (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         req_i,
  input  lsu_pkg::lsu_req_t            req_data_i,
  input  logic [lsu_pkg::WAIT_W-1:0]   wait_cycles_i,
  input  logic                         expired_i,
  input  logic                         misaligned_i,
  input  logic [lsu_pkg::STRB_W-1:0]   strb_i,
  input  logic [lsu_pkg::XLEN-1:0]     wdata_i,
  input  logic [lsu_pkg::XLEN-1:0]     ld_data_i,
  output logic                         ready_o,
  output logic                         done_o,
  output logic                         err_o,
  output lsu_pkg::lsu_req_t            cur_req_o,
  output logic                         timer_start_o,
  output logic [lsu_pkg::WAIT_W-1:0]   timer_count_o,
  output lsu_pkg::ram_port_t           ram_o,
  output logic [lsu_pkg::XLEN-1:0]     rdata_o
);
  import lsu_pkg::*;

  lsu_state_e      state_q;
  lsu_state_e      state_d;
  lsu_req_t        req_q;
  logic            err_q;
  logic [XLEN-1:0] rdata_q;
  logic            accept;
  logic            is_store;
  logic            load_done;

  // plain strobe taken only while idle
  assign accept   = req_i && (state_q == ST_IDLE);
  assign is_store = req_q.op inside {OP_SB, OP_SH, OP_SW, OP_SD};

  // aligner sees the incoming request while idle so misalignment is known at accept
  assign cur_req_o = (state_q == ST_IDLE) ? req_data_i : req_q;

  // no timer run for a refused access
  assign timer_start_o = accept && !misaligned_i;
  assign timer_count_o = wait_cycles_i;

  assign ready_o   = (state_q == ST_IDLE);
  assign done_o    = (state_q == ST_DONE);
  assign err_o     = (state_q == ST_DONE) && err_q;
  assign load_done = (state_q == ST_DONE) && !is_store && !err_q;

  // fresh load result in the done cycle and the last one held afterwards
  assign rdata_o = load_done ? ld_data_i : rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          if (misaligned_i) begin
            state_d = ST_DONE;
          end else if (expired_i) begin
            // zero wait skips straight to the RAM cycle
            state_d = ST_ACCESS;
          end else begin
            state_d = ST_WAIT;
          end
        end
      end
      ST_WAIT: begin
        if (expired_i) begin
          state_d = ST_ACCESS;
        end
      end
      ST_ACCESS: state_d = ST_DONE;
      default:   state_d = ST_IDLE;
    endcase
  end

  // RAM touched only in the access cycle
  always_comb begin
    ram_o.en    = (state_q == ST_ACCESS);
    ram_o.we    = (state_q == ST_ACCESS) && is_store;
    ram_o.idx   = req_q.addr[ADDR_W-1:ADDR_W-WORD_IDX_W];
    // loads read the full word
    ram_o.strb  = is_store ? strb_i : '1;
    ram_o.wdata = wdata_i;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      err_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        err_q <= misaligned_i;
      end
      if (load_done) begin
        rdata_q <= ld_data_i;
      end
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  // data path and byte lanes
  localparam int XLEN       = 64;
  localparam int STRB_W     = XLEN / 8;

  // 4 KiB of byte-addressed data memory
  localparam int ADDR_W     = 12;
  localparam int RAM_DEPTH  = 512;
  localparam int WORD_IDX_W = 9;

  // slave response delay of 0..15 cycles
  localparam int WAIT_W     = 4;

  // loads first, then stores
  typedef enum logic [3:0] {
    OP_LB  = 4'd0,
    OP_LH  = 4'd1,
    OP_LW  = 4'd2,
    OP_LD  = 4'd3,
    OP_LBU = 4'd4,
    OP_LHU = 4'd5,
    OP_LWU = 4'd6,
    OP_SB  = 4'd7,
    OP_SH  = 4'd8,
    OP_SW  = 4'd9,
    OP_SD  = 4'd10
  } lsu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_WAIT   = 2'd1,
    ST_ACCESS = 2'd2,
    ST_DONE   = 2'd3
  } lsu_state_e;

  // one memory request as issued by the core
  typedef struct packed {
    lsu_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [XLEN-1:0]     wdata;
  } lsu_req_t;

  // word-wide port into the data RAM
  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [WORD_IDX_W-1:0] idx;
    logic [STRB_W-1:0]     strb;
    logic [XLEN-1:0]       wdata;
  } ram_port_t;

endpackage

`default_nettype wire

// ==== source/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       req_i,
  input  lsu_pkg::lsu_req_t          req_data_i,
  input  logic [lsu_pkg::WAIT_W-1:0] wait_cycles_i,
  output logic                       ready_o,
  output logic                       done_o,
  output logic                       err_o,
  output logic [lsu_pkg::XLEN-1:0]   rdata_o
);
  import lsu_pkg::*;

  // sequencer to data path
  lsu_req_t          cur_req;
  ram_port_t         ram_port;
  logic              timer_start;
  logic [WAIT_W-1:0] timer_count;
  logic              expired;

  // data path back to sequencer
  logic              misaligned;
  logic [STRB_W-1:0] st_strb;
  logic [XLEN-1:0]   st_wdata;
  logic [XLEN-1:0]   ram_rdata;
  logic [XLEN-1:0]   ld_data;

  lsu_fsm fsm_u (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .req_data_i    (req_data_i),
    .wait_cycles_i (wait_cycles_i),
    .expired_i     (expired),
    .misaligned_i  (misaligned),
    .strb_i        (st_strb),
    .wdata_i       (st_wdata),
    .ld_data_i     (ld_data),
    .ready_o       (ready_o),
    .done_o        (done_o),
    .err_o         (err_o),
    .cur_req_o     (cur_req),
    .timer_start_o (timer_start),
    .timer_count_o (timer_count),
    .ram_o         (ram_port),
    .rdata_o       (rdata_o)
  );

  // slave response delay
  wait_timer timer_u (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .start_i   (timer_start),
    .count_i   (timer_count),
    .expired_o (expired)
  );

  store_align st_align_u (
    .req_i        (cur_req),
    .strb_o       (st_strb),
    .wdata_o      (st_wdata),
    .misaligned_o (misaligned)
  );

  load_extract ld_extract_u (
    .req_i   (cur_req),
    .rdata_i (ram_rdata),
    .data_o  (ld_data)
  );

  word_ram ram_u (
    .clk     (clk),
    .ram_i   (ram_port),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== source/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align (
  input  lsu_pkg::lsu_req_t          req_i,
  output logic [lsu_pkg::STRB_W-1:0] strb_o,
  output logic [lsu_pkg::XLEN-1:0]   wdata_o,
  output logic                       misaligned_o
);
  import lsu_pkg::*;

  logic [2:0]        off;
  logic [1:0]        size;
  logic [STRB_W-1:0] base_strb;

  // byte lane within the word
  assign off = req_i.addr[2:0];

  // log2 of access bytes for both loads and stores
  always_comb begin
    case (req_i.op)
      OP_LB, OP_LBU, OP_SB: size = 2'd0;
      OP_LH, OP_LHU, OP_SH: size = 2'd1;
      OP_LW, OP_LWU, OP_SW: size = 2'd2;
      default:              size = 2'd3;
    endcase
  end

  // lane mask at offset 0 plus the natural alignment check
  always_comb begin
    case (size)
      2'd0: begin
        base_strb    = 8'h01;
        misaligned_o = 1'b0;
      end
      2'd1: begin
        base_strb    = 8'h03;
        misaligned_o = off[0];
      end
      2'd2: begin
        base_strb    = 8'h0f;
        misaligned_o = (off[1:0] != 2'd0);
      end
      default: begin
        base_strb    = 8'hff;
        misaligned_o = (off != 3'd0);
      end
    endcase
  end

  // move mask and data up to the addressed lane
  assign strb_o  = base_strb << off;
  assign wdata_o = req_i.wdata << {off, 3'b000};

endmodule

`default_nettype wire

// ==== source/wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module wait_timer (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       start_i,
  input  logic [lsu_pkg::WAIT_W-1:0] count_i,
  output logic                       expired_o
);
  import lsu_pkg::*;

  logic [WAIT_W-1:0] cnt_q;
  logic              busy_q;

  // zero count expires in the start cycle itself
  // otherwise the last busy cycle, count cycles after start
  assign expired_o = start_i ? (count_i == '0) : (busy_q && (cnt_q == '0));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= (count_i != '0);
      // first busy cycle already counts as one
      cnt_q  <= count_i - 1'b1;
    end else if (busy_q) begin
      if (cnt_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/word_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_ram (
  input  logic                     clk,
  input  lsu_pkg::ram_port_t       ram_i,
  output logic [lsu_pkg::XLEN-1:0] rdata_o
);
  import lsu_pkg::*;

  // stands in for the AXI-lite slave RAM
  logic [XLEN-1:0] mem [RAM_DEPTH];

  // byte-strobed write port
  always_ff @(posedge clk) begin
    if (ram_i.en && ram_i.we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (ram_i.strb[b]) begin
          mem[ram_i.idx][b*8 +: 8] <= ram_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // read data one cycle after enable and held until the next read
  always_ff @(posedge clk) begin
    if (ram_i.en && !ram_i.we) begin
      rdata_o <= mem[ram_i.idx];
    end
  end

endmodule

`default_nettype wire

// ==== tests/lsu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_properties (
  input logic clk,
  input logic rst_n_i,
  input logic req_i,
  input logic ready_i,
  input logic done_i,
  input logic err_i,
  input logic misaligned_i
);

  // failure counts per property
  int unsigned n_double = 0;
  int unsigned n_err = 0;
  int unsigned n_overlap = 0;
  int unsigned n_slow = 0;
  int unsigned fail_cnt;

  logic       pend_q;
  logic [4:0] age_q;

  assign fail_cnt = n_double + n_err + n_overlap + n_slow;

  // cycles since an aligned request was taken
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
      age_q  <= '0;
    end else if (req_i && ready_i && !misaligned_i) begin
      pend_q <= 1'b1;
      age_q  <= 5'd1;
    end else if (pend_q) begin
      if (done_i) begin
        pend_q <= 1'b0;
      end else begin
        age_q <= age_q + 5'd1;
      end
    end
  end

  // done is a single-cycle pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i) done_i |=> !done_i)
    else begin
      n_double++;
      $error("done_o held for two cycles");
    end

  a_err_done: assert property (@(posedge clk) disable iff (!rst_n_i) err_i |-> done_i)
    else begin
      n_err++;
      $error("err_o without done_o");
    end

  // idle and done are separate states
  a_ready_done: assert property (@(posedge clk) disable iff (!rst_n_i) !(ready_i && done_i))
    else begin
      n_overlap++;
      $error("ready_o and done_o high together");
    end

  // worst case is 15 wait cycles plus access and done
  a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
    (pend_q && age_q >= 5'd17) |-> done_i)
    else begin
      n_slow++;
      $error("no done_o within 17 cycles of an aligned request");
    end

endmodule

bind lsu_top lsu_properties props_u (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .req_i        (req_i),
  .ready_i      (ready_o),
  .done_i       (done_o),
  .err_i        (err_o),
  .misaligned_i (misaligned)
);

`default_nettype wire

// ==== tests/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int SEED      = 76268;
  localparam int ITER      = 24;
  localparam int WIN_BASE  = 'h700;
  localparam int WIN_BYTES = 256;
  localparam int MAX_LAT   = 20;
  // window fill, per-iteration accesses of each test, wait sweep
  localparam int N_ACCESS       = WIN_BYTES / 8 + ITER * (3 + 8 + 2 + 1) + 16;
  localparam int TIMEOUT_CYCLES = N_ACCESS * 20 + 200;

  logic              clk;
  logic              rst_n;
  logic              req;
  lsu_req_t          req_data;
  logic [WAIT_W-1:0] wait_cycles;
  logic              ready;
  logic              done;
  logic              err;
  logic [XLEN-1:0]   rdata;

  // byte-wise reference of the data memory
  logic [7:0]      ref_mem [4096];
  logic [XLEN-1:0] last_load;
  int              checks;
  int              errors;

  lsu_op_e load_ops [7]  = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
  lsu_op_e store_ops [4] = '{OP_SB, OP_SH, OP_SW, OP_SD};
  // two bytes or wider so they can be misaligned
  lsu_op_e wide_ops [8]  = '{OP_LH, OP_LW, OP_LD, OP_LHU, OP_LWU, OP_SH, OP_SW, OP_SD};

  tb_clock_gen clk_gen_u (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_top i_dut (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .req_i         (req),
    .req_data_i    (req_data),
    .wait_cycles_i (wait_cycles),
    .ready_o       (ready),
    .done_o        (done),
    .err_o         (err),
    .rdata_o       (rdata)
  );

  function automatic int op_bytes(lsu_op_e op);
    case (op)
      OP_LB, OP_LBU, OP_SB: return 1;
      OP_LH, OP_LHU, OP_SH: return 2;
      OP_LW, OP_LWU, OP_SW: return 4;
      default:              return 8;
    endcase
  endfunction

  // random address in the window aligned to n bytes
  function automatic logic [ADDR_W-1:0] rand_addr(int n);
    return 12'(WIN_BASE + int'($urandom_range(WIN_BYTES - 1)) / n * n);
  endfunction

  // little-endian gather followed by sign or zero fill
  function automatic logic [XLEN-1:0] expected_load(lsu_op_e op, logic [ADDR_W-1:0] addr);
    int              n;
    logic [XLEN-1:0] raw;
    logic [XLEN-1:0] top;
    n   = op_bytes(op);
    raw = '0;
    for (int b = 0; b < n; b++) begin
      raw = raw | (64'(ref_mem[12'(addr + b)]) << (8 * b));
    end
    top = raw >> (8 * n - 1);
    if (op inside {OP_LB, OP_LH, OP_LW} && top[0]) begin
      raw = raw | ~((64'd1 << (8 * n)) - 64'd1);
    end
    return raw;
  endfunction

  task automatic check_value(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR: %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic report(string name, int err0, int chk0);
    $display("test %-12s %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  // one request with stray strobes while busy
  task automatic run_access(lsu_op_e op, logic [ADDR_W-1:0] addr, logic [XLEN-1:0] wdata,
                            logic [WAIT_W-1:0] wc, output logic [XLEN-1:0] got);
    int lat;
    int exp_lat;
    bit seen;
    bit bad;
    bad     = (int'(addr) % op_bytes(op)) != 0;
    exp_lat = bad ? 1 : int'(wc) + 2;
    // ready only moves on an edge
    while (!ready) begin
      @(posedge clk);
      #1;
    end
    req         = 1'b1;
    req_data    = '{op: op, addr: addr, wdata: wdata};
    wait_cycles = wc;
    @(posedge clk);
    #1;
    req  = 1'b0;
    lat  = 0;
    seen = 1'b0;
    got  = '0;
    while (!seen && lat < MAX_LAT) begin
      @(negedge clk);
      lat++;
      check_value("ready_o", '0, 64'(ready));
      check_value("err_o", 64'(done && bad), 64'(err));
      if (done) begin
        seen = 1'b1;
        got  = rdata;
      end
      @(posedge clk);
      #1;
      // junk payload that must not be taken
      req         = !seen && ($urandom_range(1) == 1);
      req_data    = '{op: OP_SD, addr: 12'($urandom), wdata: {$urandom, $urandom}};
      wait_cycles = 4'($urandom);
    end
    req = 1'b0;
    if (!seen) begin
      errors++;
      $display("done_o did not arrive within %0d cycles of acceptance", MAX_LAT);
    end else begin
      check_value("done_o latency", 64'(exp_lat), 64'(lat));
    end
  endtask

  task automatic do_load(lsu_op_e op, logic [ADDR_W-1:0] addr, logic [WAIT_W-1:0] wc);
    logic [XLEN-1:0] got;
    logic [XLEN-1:0] exp;
    bit              bad;
    bad = (int'(addr) % op_bytes(op)) != 0;
    // a refused load leaves the last result on rdata_o
    exp = bad ? last_load : expected_load(op, addr);
    run_access(op, addr, {$urandom, $urandom}, wc, got);
    check_value("rdata_o", exp, got);
    last_load = exp;
  endtask

  task automatic do_store(lsu_op_e op, logic [ADDR_W-1:0] addr, logic [XLEN-1:0] data);
    logic [XLEN-1:0] got;
    run_access(op, addr, data, 4'($urandom), got);
    check_value("rdata_o", last_load, got);
    if ((int'(addr) % op_bytes(op)) == 0) begin
      for (int b = 0; b < op_bytes(op); b++) begin
        ref_mem[12'(addr + b)] = 8'(data >> (8 * b));
      end
    end
  endtask

  initial begin
    int                e0;
    int                c0;
    int                n;
    logic [XLEN-1:0]   data;
    lsu_op_e           op;
    logic [ADDR_W-1:0] a;
    void'($urandom(SEED));
    req         = 1'b0;
    req_data    = '0;
    wait_cycles = '0;
    checks      = 0;
    errors      = 0;
    last_load   = '0;

    e0 = errors;
    c0 = checks;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    check_value("ready_o", 64'd1, 64'(ready));
    check_value("done_o", 64'd0, 64'(done));
    check_value("err_o", 64'd0, 64'(err));
    check_value("rdata_o", '0, rdata);
    report("reset", e0, c0);

    e0 = errors;
    c0 = checks;
    // known contents over the whole window first
    for (int w = 0; w < WIN_BYTES / 8; w++) begin
      do_store(OP_SD, 12'(WIN_BASE + 8 * w), {$urandom, $urandom});
    end
    for (int i = 0; i < ITER; i++) begin
      op = store_ops[2'($urandom)];
      a  = rand_addr(op_bytes(op));
      do_store(op, a, {$urandom, $urandom});
      // bytes outside the mask
      do_load(OP_LD, a & 12'hff8, 4'($urandom));
      op = load_ops[3'($urandom_range(6))];
      do_load(op, rand_addr(op_bytes(op)), 4'($urandom));
    end
    report("round_trip", e0, c0);

    e0 = errors;
    c0 = checks;
    for (int i = 0; i < ITER; i++) begin
      a    = rand_addr(8);
      data = {$urandom, $urandom};
      // every lane negative on even passes and positive on odd ones
      data = (i % 2 == 0) ? (data | 64'h8080_8080_8080_8080) : (data & 64'h7f7f_7f7f_7f7f_7f7f);
      do_store(OP_SD, a, data);
      for (int k = 0; k < 7; k++) begin
        n = op_bytes(load_ops[k]);
        do_load(load_ops[k], a + 12'(int'($urandom_range(7)) / n * n), 4'($urandom));
      end
    end
    report("extension", e0, c0);

    e0 = errors;
    c0 = checks;
    for (int i = 0; i < ITER; i++) begin
      op = wide_ops[3'($urandom)];
      n  = op_bytes(op);
      a  = rand_addr(8) + 12'($urandom_range(n - 1, 1));
      if (op inside {OP_SH, OP_SW, OP_SD}) begin
        do_store(op, a, {$urandom, $urandom});
      end else begin
        do_load(op, a, 4'($urandom));
      end
      // word must be unchanged
      do_load(OP_LD, a & 12'hff8, 4'($urandom));
    end
    report("misaligned", e0, c0);

    e0 = errors;
    c0 = checks;
    for (int w = 0; w < 16 + ITER; w++) begin
      op = load_ops[3'($urandom_range(6))];
      // each wait value once and then random ones
      do_load(op, rand_addr(op_bytes(op)), (w < 16) ? 4'(w) : 4'($urandom));
    end
    report("latency", e0, c0);

    $display("summary: %0d checks, %0d errors, %0d property failures",
             checks, errors, i_dut.props_u.fail_cnt);
    if (errors == 0 && i_dut.props_u.fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);
  // 10 ns period
  localparam int HALF_PERIOD = 5;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD;
      clk_o = ~clk_o;
    end
  end

  // reset low over the first two rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire
